/* Bender.yml */
package:
  name: osd_dem_uart

sources:
  - src/osd_pkg.sv
  - src/osd_statctrlif.sv
  - src/osd_uart_packetizer.sv
  - src/ring_router_mux.sv
  - src/osd_dem_uart.sv
  - target: test
    files:
      - tb/tb_osd_dem_uart.sv

/* flist.f */
src/osd_pkg.sv
src/osd_statctrlif.sv
src/osd_uart_packetizer.sv
src/ring_router_mux.sv
src/osd_dem_uart.sv
tb/tb_osd_dem_uart.sv

/* src/osd_dem_uart.sv */
`timescale 1ns/1ps

module osd_dem_uart (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [osd_pkg::id_w-1:0]   id,

   input  logic [osd_pkg::flit_w-1:0] debug_in_data,
   input  logic                       debug_in_last,
   input  logic                       debug_in_valid,
   output logic                       debug_in_ready,

   output logic [osd_pkg::flit_w-1:0] debug_out_data,
   output logic                       debug_out_last,
   output logic                       debug_out_valid,
   input  logic                       debug_out_ready,

   input  logic [7:0]                 out_char,
   input  logic                       out_valid,
   output logic                       out_ready,

   output logic [7:0]                 in_char,
   output logic                       in_valid,
   input  logic                       in_ready
);
   import osd_pkg::*;

   logic [flit_w-1:0] resp_data;
   logic              resp_last;
   logic              resp_valid;
   logic              resp_ready;

   logic [flit_w-1:0] evt_data;
   logic              evt_last;
   logic              evt_valid;
   logic              evt_ready;

   logic              stall; // cleared active bit holds back events

   // host to system direction not implemented
   assign in_char  = 8'h00;
   assign in_valid = 1'b0;

   osd_statctrlif u_statctrlif (
      .clk, .rst, .id,
      .debug_in_data, .debug_in_last, .debug_in_valid, .debug_in_ready,
      .resp_data, .resp_last, .resp_valid, .resp_ready,
      .stall
   );

   osd_uart_packetizer u_packetizer (
      .clk, .rst, .id, .stall,
      .out_char, .out_valid, .out_ready,
      .evt_data, .evt_last, .evt_valid, .evt_ready
   );

   ring_router_mux u_mux (
      .clk, .rst,
      .in_local_data (evt_data),  .in_local_last (evt_last),
      .in_local_valid(evt_valid), .in_local_ready(evt_ready),
      .in_ring_data  (resp_data), .in_ring_last  (resp_last),
      .in_ring_valid (resp_valid), .in_ring_ready (resp_ready),
      .out_data (debug_out_data),  .out_last (debug_out_last),
      .out_valid(debug_out_valid), .out_ready(debug_out_ready)
   );

endmodule

/* src/osd_pkg.sv */
package osd_pkg;

   // ####################
   // channel geometry
   // ####################

   localparam int flit_w = 16;
   localparam int id_w   = 10; // low bits of header flit

   // ####################
   // packet types
   // ####################

   // upper nibble of header flit
   typedef enum logic [3:0] {
      type_req_read   = 4'b0010,
      type_req_write  = 4'b0011,
      type_event      = 4'b1000,
      type_resp_read  = 4'b1010,
      type_resp_write = 4'b1011,
      type_resp_err   = 4'b1100
   } dii_type_e;

   // ####################
   // base register map
   // ####################

   localparam logic [flit_w-1:0] reg_mod_id      = 16'h0000; // ro
   localparam logic [flit_w-1:0] reg_mod_version = 16'h0001; // ro
   localparam logic [flit_w-1:0] reg_mod_cs      = 16'h0002; // rw with bit 0 as active

   // ####################
   // module identity
   // ####################

   localparam logic [flit_w-1:0] mod_id      = 16'h0002; // uart endpoint
   localparam logic [flit_w-1:0] mod_version = 16'h0000;

   // events and unsolicited traffic go here
   localparam logic [flit_w-1:0] host_id = 16'h0000;

endpackage

/* src/osd_statctrlif.sv */
`timescale 1ns/1ps

module osd_statctrlif (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [osd_pkg::id_w-1:0]   id,
   input  logic [osd_pkg::flit_w-1:0] debug_in_data,
   input  logic                       debug_in_last,
   input  logic                       debug_in_valid,
   output logic                       debug_in_ready,
   output logic [osd_pkg::flit_w-1:0] resp_data,
   output logic                       resp_last,
   output logic                       resp_valid,
   input  logic                       resp_ready,
   output logic                       stall
);
   import osd_pkg::*;

   typedef enum logic [2:0] {
      req_dest,
      req_hdr,
      req_addr,
      req_wdata,
      req_drain, // swallow rest of an oversized packet
      req_exec,
      req_wait
   } req_state_e;

   typedef enum logic [1:0] {
      rsp_idle,
      rsp_dest,
      rsp_hdr,
      rsp_payload
   } rsp_state_e;

   req_state_e        req_state;
   rsp_state_e        rsp_state;
   logic              shape_ok; // packet length matched its type
   logic              active;
   logic              in_take;
   logic              rsp_take;
   logic [id_w-1:0]   src_id;
   dii_type_e         req_type;
   logic [flit_w-1:0] addr_q;
   dii_type_e         rsp_type;
   logic [flit_w-1:0] rsp_value;

   assign debug_in_ready = req_state inside {req_dest, req_hdr, req_addr, req_wdata, req_drain};
   assign in_take        = debug_in_valid & debug_in_ready;
   assign rsp_take       = resp_valid & resp_ready;
   assign stall          = ~active;

   // ####################
   // request side
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         req_state <= req_dest;
         shape_ok  <= 1'b1;
         active    <= 1'b1;
      end else begin
         case (req_state)
           req_dest: begin
              if (in_take) begin
                 shape_ok  <= ~debug_in_last;
                 req_state <= debug_in_last ? req_exec : req_hdr;
              end
           end
           req_hdr: begin
              if (in_take) begin
                 if (debug_in_last) begin
                    shape_ok  <= 1'b0; // no address
                    req_state <= req_exec;
                 end else begin
                    req_state <= req_addr;
                 end
              end
           end
           req_addr: begin
              if (in_take) begin
                 if (debug_in_last) begin
                    shape_ok  <= (req_type != type_req_write);
                    req_state <= req_exec;
                 end else if (req_type == type_req_write) begin
                    req_state <= req_wdata;
                 end else begin
                    shape_ok  <= 1'b0;
                    req_state <= req_drain;
                 end
              end
           end
           req_wdata: begin
              if (in_take) begin
                 if (debug_in_last) begin
                    if (addr_q == reg_mod_cs)
                       active <= debug_in_data[0]; // write lands on final flit
                    req_state <= req_exec;
                 end else begin
                    shape_ok  <= 1'b0;
                    req_state <= req_drain;
                 end
              end
           end
           req_drain: begin
              if (in_take && debug_in_last)
                 req_state <= req_exec;
           end
           req_exec: req_state <= req_wait;
           req_wait: begin
              if (rsp_take && resp_last)
                 req_state <= req_dest;
           end
           default: req_state <= req_dest;
         endcase
      end
   end

   // captured request fields and decoded reply
   always_ff @(posedge clk) begin
      if (in_take && req_state == req_hdr) begin
         src_id   <= debug_in_data[id_w-1:0];
         req_type <= dii_type_e'(debug_in_data[15:12]);
      end
      if (in_take && req_state == req_addr)
         addr_q <= debug_in_data;
      if (req_state == req_exec) begin
         rsp_type  <= type_resp_err;
         rsp_value <= '0;
         if (shape_ok && req_type == type_req_read) begin
            case (addr_q)
              reg_mod_id: begin
                 rsp_type  <= type_resp_read;
                 rsp_value <= mod_id;
              end
              reg_mod_version: begin
                 rsp_type  <= type_resp_read;
                 rsp_value <= mod_version;
              end
              reg_mod_cs: begin
                 rsp_type  <= type_resp_read;
                 rsp_value <= {{(flit_w-1){1'b0}}, active};
              end
              default: ;
            endcase
         end else if (shape_ok && req_type == type_req_write && addr_q == reg_mod_cs) begin
            rsp_type <= type_resp_write;
         end
      end
   end

   // ####################
   // response side
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_state <= rsp_idle;
      end else begin
         case (rsp_state)
           rsp_idle:    if (req_state == req_exec) rsp_state <= rsp_dest;
           rsp_dest:    if (rsp_take) rsp_state <= rsp_hdr;
           rsp_hdr:     if (rsp_take) rsp_state <= resp_last ? rsp_idle : rsp_payload;
           rsp_payload: if (rsp_take) rsp_state <= rsp_idle;
           default:     rsp_state <= rsp_idle;
         endcase
      end
   end

   always_comb begin
      resp_valid = 1'b0;
      resp_last  = 1'b0;
      resp_data  = '0;
      case (rsp_state)
        rsp_dest: begin
           resp_valid = 1'b1;
           resp_data  = {{(flit_w-id_w){1'b0}}, src_id}; // back to requester
        end
        rsp_hdr: begin
           resp_valid = 1'b1;
           resp_data  = {rsp_type, 2'b00, id};
           resp_last  = (rsp_type != type_resp_read); // write ack and error end here
        end
        rsp_payload: begin
           resp_valid = 1'b1;
           resp_data  = rsp_value;
           resp_last  = 1'b1;
        end
        default: ;
      endcase
   end

endmodule

/* src/osd_uart_packetizer.sv */
`timescale 1ns/1ps

module osd_uart_packetizer (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [osd_pkg::id_w-1:0]   id,
   input  logic                       stall,
   input  logic [7:0]                 out_char,
   input  logic                       out_valid,
   output logic                       out_ready,
   output logic [osd_pkg::flit_w-1:0] evt_data,
   output logic                       evt_last,
   output logic                       evt_valid,
   input  logic                       evt_ready
);
   import osd_pkg::*;

   // one state per flit of the event
   typedef enum logic [1:0] {
      st_dest,
      st_hdr,
      st_char
   } state_e;

   state_e state;
   logic   evt_take;

   assign evt_take = evt_valid & evt_ready;

   // ####################
   // flit sequencing
   // ####################

   // stall only holds back the first flit, a started packet always finishes
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_dest;
      end else begin
         case (state)
           st_dest: begin
              if (evt_take)
                 state <= st_hdr;
           end
           st_hdr: begin
              if (evt_take)
                 state <= st_char;
           end
           st_char: begin
              if (evt_take)
                 state <= st_dest;
           end
           default: state <= st_dest;
         endcase
      end
   end

   // ####################
   // flit contents
   // ####################

   always_comb begin
      evt_valid = 1'b0;
      evt_last  = 1'b0;
      evt_data  = host_id;
      out_ready = 1'b0;
      case (state)
        st_dest: begin
           evt_valid = out_valid & ~stall;
           evt_data  = host_id;
        end
        st_hdr: begin
           evt_valid = 1'b1;
           evt_data  = {type_event, 2'b00, id};
        end
        st_char: begin
           evt_valid = 1'b1;
           evt_last  = 1'b1;
           evt_data  = {{(flit_w-8){1'b0}}, out_char};
           out_ready = evt_ready; // char consumed with the last flit
        end
        default: ;
      endcase
   end

endmodule

/* src/ring_router_mux.sv */
`timescale 1ns/1ps

module ring_router_mux (
   input  logic                       clk,
   input  logic                       rst,

   input  logic [osd_pkg::flit_w-1:0] in_local_data,
   input  logic                       in_local_last,
   input  logic                       in_local_valid,
   output logic                       in_local_ready,

   input  logic [osd_pkg::flit_w-1:0] in_ring_data,
   input  logic                       in_ring_last,
   input  logic                       in_ring_valid,
   output logic                       in_ring_ready,

   output logic [osd_pkg::flit_w-1:0] out_data,
   output logic                       out_last,
   output logic                       out_valid,
   input  logic                       out_ready
);

   typedef enum logic {
      sel_local,
      sel_ring
   } sel_e;

   sel_e grant_q; // owner of the packet in flight
   sel_e sel;
   logic locked;  // mid packet

   // ring wins when nothing is in flight
   always_comb begin
      if (locked)
         sel = grant_q;
      else if (in_ring_valid)
         sel = sel_ring;
      else
         sel = sel_local;
   end

   // ####################
   // data path
   // ####################

   always_comb begin
      if (sel == sel_ring) begin
         out_data  = in_ring_data;
         out_last  = in_ring_last;
         out_valid = in_ring_valid;
      end else begin
         out_data  = in_local_data;
         out_last  = in_local_last;
         out_valid = in_local_valid;
      end
   end

   assign in_ring_ready  = out_ready & (sel == sel_ring);
   assign in_local_ready = out_ready & (sel == sel_local);

   // ####################
   // grant lock
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         locked  <= 1'b0;
         grant_q <= sel_local;
      end else if (out_valid && out_ready) begin
         locked  <= ~out_last; // release after last flit
         grant_q <= sel;
      end
   end

endmodule

/* tb/tb_osd_dem_uart.sv */
`timescale 1ns/1ps

module tb_osd_dem_uart;

   localparam int n_entries    = 18;
   localparam int limit_cycles = n_entries * 40 + 100;

   localparam logic [9:0] own_id   = 10'h025;
   localparam logic [9:0] host_src = 10'h003; // requester id

   // packet types as seen on the wire
   localparam logic [3:0] t_req_read   = 4'h2;
   localparam logic [3:0] t_req_write  = 4'h3;
   localparam logic [3:0] t_event      = 4'h8;
   localparam logic [3:0] t_resp_read  = 4'ha;
   localparam logic [3:0] t_resp_write = 4'hb;
   localparam logic [3:0] t_resp_err   = 4'hc;

   localparam int kind_char  = 0;
   localparam int kind_read  = 1;
   localparam int kind_write = 2;

   logic        clk;
   logic        rst;
   logic [9:0]  id;
   logic [15:0] debug_in_data;
   logic        debug_in_last;
   logic        debug_in_valid;
   logic        debug_in_ready;
   logic [15:0] debug_out_data;
   logic        debug_out_last;
   logic        debug_out_valid;
   logic        debug_out_ready;
   logic [7:0]  out_char;
   logic        out_valid;
   logic        out_ready;
   logic [7:0]  in_char;
   logic        in_valid;
   logic        in_ready;

   // ####################
   // stimulus table
   // ####################

   int          tab_kind [n_entries];
   logic [15:0] tab_req  [n_entries][4];
   logic [15:0] tab_exp  [n_entries][3];
   int          tab_len  [n_entries];
   logic [2:0]  tab_last [n_entries];
   int          tab_chk  [n_entries]; // 1 drain chars then snapshot, 2 compare
   int          n_tab;
   logic        model_active;

   int          exp_resp_q[$];
   int          exp_evt_q[$];
   logic [15:0] cur_data[$];
   logic        cur_last[$];
   logic [7:0]  char_q[$];
   logic        char_busy;
   int          resp_cnt;
   int          evt_cnt;
   int          ready_cnt;
   int          snap_ready;
   int          snap_evt;
   int          n_chars;
   int          n_reqs;
   int          val_errs;
   int          other_errs;
   logic [31:0] rng;

   osd_dem_uart dut (
      .clk, .rst, .id,
      .debug_in_data, .debug_in_last, .debug_in_valid, .debug_in_ready,
      .debug_out_data, .debug_out_last, .debug_out_valid, .debug_out_ready,
      .out_char, .out_valid, .out_ready,
      .in_char, .in_valid, .in_ready
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   function automatic logic [31:0] next_rand(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_char(input logic [7:0] c);
      tab_kind[n_tab]   = kind_char;
      tab_req[n_tab][0] = {8'h00, c}; // char rides in word 0
      tab_req[n_tab][1] = 16'h0000;
      tab_req[n_tab][2] = 16'h0000;
      tab_req[n_tab][3] = 16'h0000;
      tab_exp[n_tab][0] = 16'h0000;   // host
      tab_exp[n_tab][1] = {t_event, 2'b00, own_id};
      tab_exp[n_tab][2] = {8'h00, c};
      tab_len[n_tab]    = 3;
      tab_last[n_tab]   = 3'b100;
      tab_chk[n_tab]    = 0;
      n_tab++;
   endtask

   // expected reply follows the register map and the running cs value
   task automatic add_read(input logic [15:0] addr, input int chk);
      tab_kind[n_tab]   = kind_read;
      tab_req[n_tab][0] = {6'h00, own_id};
      tab_req[n_tab][1] = {t_req_read, 2'b00, host_src};
      tab_req[n_tab][2] = addr;
      tab_req[n_tab][3] = 16'h0000;
      tab_exp[n_tab][0] = {6'h00, host_src};
      tab_exp[n_tab][1] = {t_resp_read, 2'b00, own_id};
      tab_exp[n_tab][2] = 16'h0000;
      tab_len[n_tab]    = 3;
      tab_last[n_tab]   = 3'b100;
      case (addr)
        16'h0000: tab_exp[n_tab][2] = 16'h0002;
        16'h0001: tab_exp[n_tab][2] = 16'h0000;
        16'h0002: tab_exp[n_tab][2] = {15'h0000, model_active};
        default: begin
           tab_exp[n_tab][1] = {t_resp_err, 2'b00, own_id};
           tab_len[n_tab]    = 2;
           tab_last[n_tab]   = 3'b010;
        end
      endcase
      tab_chk[n_tab] = chk;
      n_tab++;
   endtask

   task automatic add_write(input logic [15:0] addr, input logic [15:0] data, input int chk);
      tab_kind[n_tab]   = kind_write;
      tab_req[n_tab][0] = {6'h00, own_id};
      tab_req[n_tab][1] = {t_req_write, 2'b00, host_src};
      tab_req[n_tab][2] = addr;
      tab_req[n_tab][3] = data;
      tab_exp[n_tab][0] = {6'h00, host_src};
      tab_exp[n_tab][1] = {t_resp_err, 2'b00, own_id};
      tab_exp[n_tab][2] = 16'h0000;
      tab_len[n_tab]    = 2;
      tab_last[n_tab]   = 3'b010;
      if (addr == 16'h0002) begin
         tab_exp[n_tab][1] = {t_resp_write, 2'b00, own_id};
         model_active      = data[0];
      end
      tab_chk[n_tab] = chk;
      n_tab++;
   endtask

   // ####################
   // drivers
   // ####################

   task automatic send_flit(input logic [15:0] d, input logic l);
      debug_in_data  = d;
      debug_in_last  = l;
      debug_in_valid = 1'b1;
      @(posedge clk);
      while (!debug_in_ready) @(posedge clk);
      #1;
      debug_in_valid = 1'b0;
      debug_in_last  = 1'b0;
   endtask

   task automatic run_request(input int e);
      int want;
      want = resp_cnt + 1;
      exp_resp_q.push_back(e);
      send_flit(tab_req[e][0], 1'b0);
      send_flit(tab_req[e][1], 1'b0);
      if (tab_kind[e] == kind_read) begin
         send_flit(tab_req[e][2], 1'b1);
      end else begin
         send_flit(tab_req[e][2], 1'b0);
         send_flit(tab_req[e][3], 1'b1);
      end
      while (resp_cnt < want) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_chars_idle();
      while (char_q.size() != 0 || char_busy) begin
         @(posedge clk);
         #1;
      end
   endtask

   always @(posedge clk) begin
      #1;
      rng             = next_rand(rng);
      debug_out_ready = (rng[1:0] != 2'b00); // ready about 3 cycles in 4
   end

   // system side character source
   always @(posedge clk) begin
      if (!rst) begin
         if (char_busy && out_ready) begin
            char_q.delete(0);
            char_busy = 1'b0;
         end
         if (!char_busy && char_q.size() != 0) begin
            char_busy = 1'b1;
            #1;
            out_char  = char_q[0];
            out_valid = 1'b1;
         end else if (!char_busy) begin
            #1;
            out_valid = 1'b0;
         end
      end
   end

   // ####################
   // collector and checks
   // ####################

   task automatic check_packet();
      int e;
      int len;
      bit is_evt;
      len = cur_data.size();
      if (len < 2) begin
         other_errs++;
         $display("packet of %0d flit(s) ended before its header flit", len);
      end else begin
         is_evt = (cur_data[1][15:12] == t_event);
         if ((is_evt && exp_evt_q.size() == 0) || (!is_evt && exp_resp_q.size() == 0)) begin
            other_errs++;
            $display("packet with header %h arrived while none was expected", cur_data[1]);
         end else begin
            if (is_evt) begin
               e = exp_evt_q.pop_front();
               evt_cnt++;
            end else begin
               e = exp_resp_q.pop_front();
               resp_cnt++;
            end
            if (len != tab_len[e]) begin
               val_errs++;
               $display("ERR debug_out_last entry %0d packet length: expected %h, got %h",
                        e, tab_len[e], len);
            end
            for (int i = 0; i < len && i < tab_len[e]; i++) begin
               if (cur_data[i] !== tab_exp[e][i]) begin
                  val_errs++;
                  $display("ERR debug_out_data entry %0d flit %0d: expected %h, got %h",
                           e, i, tab_exp[e][i], cur_data[i]);
               end
               if (cur_last[i] !== tab_last[e][i]) begin
                  val_errs++;
                  $display("ERR debug_out_last entry %0d flit %0d: expected %h, got %h",
                           e, i, tab_last[e][i], cur_last[i]);
               end
            end
         end
      end
      cur_data.delete();
      cur_last.delete();
   endtask

   always @(posedge clk) begin
      if (!rst && debug_out_valid && debug_out_ready) begin
         cur_data.push_back(debug_out_data);
         cur_last.push_back(debug_out_last);
         if (debug_out_last)
            check_packet();
      end
   end

   always @(posedge clk) begin
      if (!rst && out_ready) begin
         ready_cnt++;
         if (!out_valid) begin
            other_errs++;
            $display("out_ready went high with no character offered");
         end
      end
   end

   // reverse character direction stays idle
   always @(posedge clk) begin
      if (!rst && in_valid !== 1'b0) begin
         val_errs++;
         $display("ERR in_valid: expected %h, got %h", 1'b0, in_valid);
      end
      if (!rst && in_char !== 8'h00) begin
         val_errs++;
         $display("ERR in_char: expected %h, got %h", 8'h00, in_char);
      end
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("timeout, run did not complete within %0d cycles", limit_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ####################
   // main sequence
   // ####################

   initial begin
      rst             = 1'b1;
      id              = own_id;
      debug_in_data   = 16'h0000;
      debug_in_last   = 1'b0;
      debug_in_valid  = 1'b0;
      debug_out_ready = 1'b0;
      out_char        = 8'h00;
      out_valid       = 1'b0;
      in_ready        = 1'b0;
      rng             = 32'd67;
      char_busy       = 1'b0;
      model_active    = 1'b1;
      n_tab           = 0;
      resp_cnt        = 0;
      evt_cnt         = 0;
      ready_cnt       = 0;
      snap_ready      = 0;
      snap_evt        = 0;
      n_chars         = 0;
      n_reqs          = 0;
      val_errs        = 0;
      other_errs      = 0;

      add_char(8'h41);
      add_read(16'h0000, 0);
      add_char(8'h62);
      add_read(16'h0001, 0);
      add_read(16'h0007, 0);          // unknown address
      add_char(8'hcc);
      add_write(16'h0002, 16'h0000, 1); // stall events
      add_char(8'h64);                // held back
      add_read(16'h0002, 2);
      add_write(16'h0002, 16'h0001, 0); // release
      add_read(16'h0002, 0);
      add_char(8'h65);
      add_char(8'h66);
      add_write(16'h0005, 16'h1234, 0);
      add_char(8'h67);
      add_read(16'h0000, 0);
      add_char(8'h00);
      add_char(8'hff);

      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      for (int e = 0; e < n_tab; e++) begin
         if (tab_chk[e] == 1)
            wait_chars_idle();
         if (tab_kind[e] == kind_char) begin
            exp_evt_q.push_back(e);
            char_q.push_back(tab_req[e][0][7:0]);
            n_chars++;
            @(posedge clk);
            #1;
         end else begin
            run_request(e);
            n_reqs++;
         end
         if (tab_chk[e] == 1) begin
            snap_ready = ready_cnt;
            snap_evt   = evt_cnt;
         end
         if (tab_chk[e] == 2) begin
            if (ready_cnt != snap_ready) begin
               val_errs++;
               $display("ERR out_ready count while stalled: expected %h, got %h",
                        snap_ready, ready_cnt);
            end
            if (evt_cnt != snap_evt) begin
               val_errs++;
               $display("ERR debug_out_data event packets while stalled: expected %h, got %h",
                        snap_evt, evt_cnt);
            end
         end
      end

      wait_chars_idle();
      while (exp_resp_q.size() != 0 || exp_evt_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
      repeat (20) @(posedge clk); // room for stray flits

      if (ready_cnt != n_chars) begin
         val_errs++;
         $display("ERR out_ready pulses: expected %h, got %h", n_chars, ready_cnt);
      end
      if (evt_cnt != n_chars) begin
         val_errs++;
         $display("ERR debug_out_data event packets: expected %h, got %h", n_chars, evt_cnt);
      end
      if (resp_cnt != n_reqs) begin
         val_errs++;
         $display("ERR debug_out_data responses: expected %h, got %h", n_reqs, resp_cnt);
      end
      if (cur_data.size() != 0) begin
         other_errs++;
         $display("a packet on debug_out was left without its last flit");
      end

      $display("errors: %0d value, %0d other", val_errs, other_errs);
      if (val_errs + other_errs == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
